/* hw/rx_buffer_sink.sv */
// RX buffer sink: writes one frame into a RAM slot and measures its byte length
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_buffer_sink
    import rx_stream_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               start,
    input  wire logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] base_addr,
    input  wire rx_beat_t                           rx_beat,
    input  wire logic                               rx_valid,
    output logic                                    rx_ready,
    output ram_wr_t                                 wr,
    output logic                                    wr_en,
    output logic                                    done,
    output logic [`RX_LEN_WIDTH-1:0]                frame_len
);

    localparam int SLOT_WORDS = `RX_SLOT_BYTES / `RX_KEEP_WIDTH;

    logic                               armed;
    logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] base_q;
    logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] offset;
    logic [`RX_LEN_WIDTH-1:0]           len_q;
    logic                               accept;
    logic                               in_slot;

    function automatic logic [`RX_LEN_WIDTH-1:0] keep_bytes(
        input logic [`RX_KEEP_WIDTH-1:0] keep
    );
        logic [`RX_LEN_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < `RX_KEEP_WIDTH; i++) begin
            n = n + keep[i];
        end
        return n;
    endfunction

    assign rx_ready  = armed;
    assign accept    = armed && rx_valid;
    assign in_slot   = offset < (`RX_RAM_WORD_ADDR_WIDTH)'(SLOT_WORDS);
    assign frame_len = len_q;

    // Beats past the slot end are dropped but still measured
    assign wr_en   = accept && in_slot;
    assign wr.addr = base_q + offset;
    assign wr.data = rx_beat.data;
    assign wr.be   = rx_beat.keep;

    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= base_addr;
            offset <= '0;
            len_q  <= '0;
        end else if (accept) begin
            if (in_slot) begin
                offset <= offset + 1'b1;
            end
            len_q <= len_q + keep_bytes(rx_beat.keep);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= accept && rx_beat.last;
            if (start) begin
                armed <= 1'b1;
            end else if (accept && rx_beat.last) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rx_consts.svh */
// Receive path constants for stream, DMA, RAM and queue dimensions
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// Frame stream
`define RX_DATA_WIDTH 64
`define RX_KEEP_WIDTH 8
`define RX_LEN_WIDTH 16

// Host side DMA
`define DMA_ADDR_WIDTH 64
`define DMA_STATUS_ERR_WIDTH 4

// Packet RAM with one slot per frame in flight
`define RX_SLOT_COUNT 4
`define RX_SLOT_BYTES 1024
`define RX_RAM_ADDR_WIDTH 12
`define RX_RAM_WORD_ADDR_WIDTH 9

// Queueing
`define RX_DESC_FIFO_DEPTH 16
`define RX_REQ_CNT_WIDTH 6

`endif

/* hw/rx_desc_fifo.sv */
// RX descriptor FIFO: holds host buffer descriptors until the engine takes one
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_desc_fifo
    import rx_desc_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire rx_desc_t in_desc,
    input  wire logic     in_valid,
    output logic          in_ready,
    output rx_desc_t      out_desc,
    output logic          out_valid,
    input  wire logic     out_ready
);

    localparam int PTR_WIDTH = $clog2(`RX_DESC_FIFO_DEPTH);

    rx_desc_t               mem [`RX_DESC_FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH:0]     fill;
    logic                   push;
    logic                   pop;

    assign in_ready  = fill != (PTR_WIDTH+1)'(`RX_DESC_FIFO_DEPTH);
    assign out_valid = fill != '0;
    assign out_desc  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_desc;
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rx_desc_pkg.sv */
// Receive descriptor package with host buffers, DMA commands, completions and engine states
`default_nettype none

`include "rx_consts.svh"

package rx_desc_pkg;

    // Host buffer handed in by the driver
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] dma_addr;
        logic [`RX_LEN_WIDTH-1:0]   buf_len;
    } rx_desc_t;

    // Command to the external DMA engine to copy a RAM slot into a host buffer
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0]    dma_addr;
        logic [`RX_RAM_ADDR_WIDTH-1:0] ram_addr;
        logic [`RX_LEN_WIDTH-1:0]      len;
    } dma_wr_desc_t;

    // Completion record returned to the host
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] dma_addr;
        logic [`RX_LEN_WIDTH-1:0]   len;
        logic                       error;
    } rx_cpl_t;

    // Per-frame sequence of the receive engine
    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        DMA_ISSUE,
        DMA_WAIT,
        CPL
    } rx_engine_state_t;

endpackage

`default_nettype wire

/* hw/rx_engine.sv */
// RX engine: per frame takes a descriptor, captures into a slot, issues DMA, completes
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_engine
    import rx_desc_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               req_valid,
    output logic                                    req_ready,
    input  wire rx_desc_t                           desc,
    input  wire logic                               desc_valid,
    output logic                                    desc_ready,
    output logic                                    start,
    output logic [`RX_RAM_WORD_ADDR_WIDTH-1:0]      base_addr,
    input  wire logic                               done,
    input  wire logic [`RX_LEN_WIDTH-1:0]           frame_len,
    input  wire logic [`RX_LEN_WIDTH-1:0]           mtu,
    output dma_wr_desc_t                            dma_desc,
    output logic                                    dma_desc_valid,
    input  wire logic                               dma_desc_ready,
    input  wire logic                               dma_status_valid,
    input  wire logic [`DMA_STATUS_ERR_WIDTH-1:0]   dma_status_error,
    output rx_cpl_t                                 cpl,
    output logic                                    cpl_valid,
    input  wire logic                               cpl_ready
);

    localparam int SLOT_WORDS = `RX_SLOT_BYTES / `RX_KEEP_WIDTH;
    localparam int SLOT_WIDTH = $clog2(`RX_SLOT_COUNT);

    rx_engine_state_t        state;
    rx_engine_state_t        state_next;
    rx_desc_t                desc_q;
    logic [`RX_LEN_WIDTH-1:0] len_q;
    logic                    err_q;
    logic [SLOT_WIDTH-1:0]   slot_idx;
    logic                    take;
    logic                    len_ok;

    // Request and descriptor are consumed together
    assign take       = (state == IDLE) && req_valid && desc_valid;
    assign req_ready  = (state == IDLE) && desc_valid;
    assign desc_ready = (state == IDLE) && req_valid;
    assign start      = take;
    assign base_addr  = (`RX_RAM_WORD_ADDR_WIDTH)'(slot_idx * SLOT_WORDS);

    // Must fit both the link MTU and the host buffer
    assign len_ok = (frame_len <= mtu) && (frame_len <= desc_q.buf_len);

    assign dma_desc_valid    = state == DMA_ISSUE;
    assign dma_desc.dma_addr = desc_q.dma_addr;
    assign dma_desc.ram_addr = (`RX_RAM_ADDR_WIDTH)'(slot_idx * `RX_SLOT_BYTES);
    assign dma_desc.len      = len_q;

    assign cpl_valid    = state == CPL;
    assign cpl.dma_addr = desc_q.dma_addr;
    assign cpl.len      = len_q;
    assign cpl.error    = err_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (take) state_next = CAPTURE;
            CAPTURE:   if (done) state_next = len_ok ? DMA_ISSUE : CPL;
            DMA_ISSUE: if (dma_desc_ready) state_next = DMA_WAIT;
            DMA_WAIT:  if (dma_status_valid) state_next = CPL;
            CPL:       if (cpl_ready) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // Frame record
    always_ff @(posedge clk) begin
        if (take) begin
            desc_q <= desc;
        end
        if (state == CAPTURE && done) begin
            len_q <= frame_len;
            err_q <= !len_ok;
        end
        if (state == DMA_WAIT && dma_status_valid) begin
            err_q <= dma_status_error != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            slot_idx <= '0;
        end else begin
            state <= state_next;
            // Next frame goes to the next slot
            if (state == CPL && cpl_ready) begin
                if (slot_idx == SLOT_WIDTH'(`RX_SLOT_COUNT - 1)) begin
                    slot_idx <= '0;
                end else begin
                    slot_idx <= slot_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rx_interface.sv */
// RX interface top: request generator, descriptor FIFO, sink, packet RAM and engine
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_interface
    import rx_stream_pkg::*;
    import rx_desc_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire rx_beat_t                           rx_beat,
    input  wire logic                               rx_valid,
    output logic                                    rx_ready,
    input  wire rx_desc_t                           desc,
    input  wire logic                               desc_valid,
    output logic                                    desc_ready,
    output dma_wr_desc_t                            dma_desc,
    output logic                                    dma_desc_valid,
    input  wire logic                               dma_desc_ready,
    input  wire logic                               dma_status_valid,
    input  wire logic [`DMA_STATUS_ERR_WIDTH-1:0]   dma_status_error,
    output rx_cpl_t                                 cpl,
    output logic                                    cpl_valid,
    input  wire logic                               cpl_ready,
    input  wire logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] ram_rd_addr,
    input  wire logic                               ram_rd_en,
    output logic [`RX_DATA_WIDTH-1:0]               ram_rd_data,
    input  wire logic [`RX_LEN_WIDTH-1:0]           mtu
);

    logic                               req_valid;
    logic                               req_ready;
    rx_desc_t                           fifo_desc;
    logic                               fifo_valid;
    logic                               fifo_ready;
    logic                               sink_start;
    logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] sink_base;
    logic                               sink_done;
    logic [`RX_LEN_WIDTH-1:0]           sink_len;
    ram_wr_t                            ram_wr;
    logic                               ram_wr_en;

    rx_req_gen i_rx_req_gen (
        .clk       (clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_last   (rx_beat.last),
        .req_valid (req_valid),
        .req_ready (req_ready)
    );

    rx_desc_fifo i_rx_desc_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_desc   (desc),
        .in_valid  (desc_valid),
        .in_ready  (desc_ready),
        .out_desc  (fifo_desc),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    rx_buffer_sink i_rx_buffer_sink (
        .clk       (clk),
        .rst       (rst),
        .start     (sink_start),
        .base_addr (sink_base),
        .rx_beat   (rx_beat),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .wr        (ram_wr),
        .wr_en     (ram_wr_en),
        .done      (sink_done),
        .frame_len (sink_len)
    );

    rx_packet_ram i_rx_packet_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .wr_en   (ram_wr_en),
        .rd_addr (ram_rd_addr),
        .rd_en   (ram_rd_en),
        .rd_data (ram_rd_data)
    );

    rx_engine i_rx_engine (
        .clk              (clk),
        .rst              (rst),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .desc             (fifo_desc),
        .desc_valid       (fifo_valid),
        .desc_ready       (fifo_ready),
        .start            (sink_start),
        .base_addr        (sink_base),
        .done             (sink_done),
        .frame_len        (sink_len),
        .mtu              (mtu),
        .dma_desc         (dma_desc),
        .dma_desc_valid   (dma_desc_valid),
        .dma_desc_ready   (dma_desc_ready),
        .dma_status_valid (dma_status_valid),
        .dma_status_error (dma_status_error),
        .cpl              (cpl),
        .cpl_valid        (cpl_valid),
        .cpl_ready        (cpl_ready)
    );

endmodule

`default_nettype wire

/* hw/rx_packet_ram.sv */
// RX packet RAM: byte-enabled write port from the sink, registered read port for DMA
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_packet_ram
    import rx_stream_pkg::*;
(
    input  wire logic                               clk,
    input  wire ram_wr_t                            wr,
    input  wire logic                               wr_en,
    input  wire logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] rd_addr,
    input  wire logic                               rd_en,
    output logic [`RX_DATA_WIDTH-1:0]               rd_data
);

    localparam int WORDS = `RX_SLOT_COUNT * `RX_SLOT_BYTES / `RX_KEEP_WIDTH;

    logic [`RX_DATA_WIDTH-1:0] mem [WORDS];

    // Write lanes one byte at a time
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `RX_KEEP_WIDTH; i++) begin
                if (wr.be[i]) begin
                    mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
                end
            end
        end
    end

    // Data appears the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/rx_req_gen.sv */
// RX request generator: turns frame starts on the stream into pending requests
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_req_gen (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic rx_valid,
    input  wire logic rx_ready,
    input  wire logic rx_last,
    output logic      req_valid,
    input  wire logic req_ready
);

    logic                         frame_active;
    logic [`RX_REQ_CNT_WIDTH-1:0] req_cnt;
    logic                         frame_start;
    logic                         req_take;

    // A frame counts on its first valid beat, accepted or not
    assign frame_start = rx_valid && !frame_active;
    assign req_valid   = req_cnt != '0;
    assign req_take    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_active <= 1'b0;
            req_cnt      <= '0;
        end else begin
            if (frame_start && !req_take) begin
                // Saturate rather than wrap
                if (req_cnt != '1) begin
                    req_cnt <= req_cnt + 1'b1;
                end
            end else if (!frame_start && req_take) begin
                req_cnt <= req_cnt - 1'b1;
            end

            if (frame_start) begin
                frame_active <= 1'b1;
            end
            // Single-beat frames open and close in the same cycle
            if (rx_valid && rx_ready && rx_last) begin
                frame_active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rx_stream_pkg.sv */
// Received frame stream package: stream beats and packet RAM writes
`default_nettype none

`include "rx_consts.svh"

package rx_stream_pkg;

    // One beat of the incoming frame stream
    typedef struct packed {
        logic [`RX_DATA_WIDTH-1:0] data;
        logic [`RX_KEEP_WIDTH-1:0] keep;
        logic                      last;
    } rx_beat_t;

    // One word write into the packet RAM
    typedef struct packed {
        logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] addr;
        logic [`RX_DATA_WIDTH-1:0]          data;
        logic [`RX_KEEP_WIDTH-1:0]          be;
    } ram_wr_t;

endpackage

`default_nettype wire

/* rx_interface.f */
+incdir+hw
hw/rx_stream_pkg.sv
hw/rx_desc_pkg.sv
hw/rx_req_gen.sv
hw/rx_desc_fifo.sv
hw/rx_packet_ram.sv
hw/rx_buffer_sink.sv
hw/rx_engine.sv
hw/rx_interface.sv
test/rx_clock_gen.sv
test/rx_interface_assertions.sv
test/rx_interface_tb.sv

/* test/rx_clock_gen.sv */
// Testbench clock and reset source: 100 ns clock, reset held for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module rx_clock_gen (
    output logic clk,
    output logic rst
);

    // Half period of 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* test/rx_interface_assertions.sv */
// RX interface protocol checks, bound onto the top level
`timescale 1ns/1ps
`default_nettype none

module rx_interface_assertions
    import rx_desc_pkg::*;
(
    input wire logic         clk,
    input wire logic         rst,
    input wire logic         rx_ready,
    input wire logic         req_valid,
    input wire dma_wr_desc_t dma_desc,
    input wire logic         dma_desc_valid,
    input wire logic         dma_desc_ready,
    input wire rx_cpl_t      cpl,
    input wire logic         cpl_valid,
    input wire logic         cpl_ready
);

    int fail_count = 0;

    // Registers settle after the first reset edge
    reset_outputs_low: assert property (@(posedge clk)
        (rst ##1 rst) |-> (!rx_ready && !req_valid && !dma_desc_valid && !cpl_valid))
    else begin
        fail_count++;
        $error("Control output high during reset");
    end

    dma_desc_held: assert property (@(posedge clk) disable iff (rst)
        (dma_desc_valid && !dma_desc_ready) |=> (dma_desc_valid && $stable(dma_desc)))
    else begin
        fail_count++;
        $error("DMA command changed or dropped before dma_desc_ready");
    end

    cpl_held: assert property (@(posedge clk) disable iff (rst)
        (cpl_valid && !cpl_ready) |=> (cpl_valid && $stable(cpl)))
    else begin
        fail_count++;
        $error("Completion changed or dropped before cpl_ready");
    end

    // Sink must be idle while a completion is pending
    no_rx_during_cpl: assert property (@(posedge clk) disable iff (rst)
        !(rx_ready && cpl_valid))
    else begin
        fail_count++;
        $error("rx_ready high while cpl_valid is high");
    end

endmodule

bind rx_interface rx_interface_assertions i_rx_interface_assertions (
    .clk            (clk),
    .rst            (rst),
    .rx_ready       (rx_ready),
    .req_valid      (req_valid),
    .dma_desc       (dma_desc),
    .dma_desc_valid (dma_desc_valid),
    .dma_desc_ready (dma_desc_ready),
    .cpl            (cpl),
    .cpl_valid      (cpl_valid),
    .cpl_ready      (cpl_ready)
);

`default_nettype wire

/* test/rx_interface_tb.sv */
// RX interface testbench with frame and descriptor stimulus and DMA and completion models
`timescale 1ns/1ps
`default_nettype none

`include "rx_consts.svh"

module rx_interface_tb
    import rx_stream_pkg::*;
    import rx_desc_pkg::*;
();

    localparam int WAIT_LIMIT = 5000;

    logic                               clk;
    logic                               rst;
    rx_beat_t                           rx_beat = '0;
    logic                               rx_valid = 1'b0;
    logic                               rx_ready;
    rx_desc_t                           desc = '0;
    logic                               desc_valid = 1'b0;
    logic                               desc_ready;
    dma_wr_desc_t                       dma_desc;
    logic                               dma_desc_valid;
    logic                               dma_desc_ready = 1'b0;
    logic                               dma_status_valid = 1'b0;
    logic [`DMA_STATUS_ERR_WIDTH-1:0]   dma_status_error = '0;
    rx_cpl_t                            cpl;
    logic                               cpl_valid;
    logic                               cpl_ready = 1'b0;
    logic [`RX_RAM_WORD_ADDR_WIDTH-1:0] ram_rd_addr = '0;
    logic                               ram_rd_en = 1'b0;
    logic [`RX_DATA_WIDTH-1:0]          ram_rd_data;
    logic [`RX_LEN_WIDTH-1:0]           mtu = 16'd1500;

    integer                           seed = 32'hf44;
    dma_wr_desc_t                     want_dma[$];
    rx_cpl_t                          want_cpl[$];
    logic [`RX_DATA_WIDTH-1:0]        sent_data[$];
    logic [`RX_KEEP_WIDTH-1:0]        sent_keep[$];
    logic [`DMA_STATUS_ERR_WIDTH-1:0] status_err = '0;
    bit                               stall_en = 1'b0;
    int                               status_delay = 0;
    int                               exp_slot = 0;
    int                               frames_expected = 0;
    int                               cpl_count = 0;
    int                               checks = 0;
    int                               errors = 0;
    int                               errors_at_start = 0;
    int                               tests_run = 0;
    int                               tests_failed = 0;

    rx_clock_gen i_rx_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    rx_interface i_rx_interface (
        .clk              (clk),
        .rst              (rst),
        .rx_beat          (rx_beat),
        .rx_valid         (rx_valid),
        .rx_ready         (rx_ready),
        .desc             (desc),
        .desc_valid       (desc_valid),
        .desc_ready       (desc_ready),
        .dma_desc         (dma_desc),
        .dma_desc_valid   (dma_desc_valid),
        .dma_desc_ready   (dma_desc_ready),
        .dma_status_valid (dma_status_valid),
        .dma_status_error (dma_status_error),
        .cpl              (cpl),
        .cpl_valid        (cpl_valid),
        .cpl_ready        (cpl_ready),
        .ram_rd_addr      (ram_rd_addr),
        .ram_rd_en        (ram_rd_en),
        .ram_rd_data      (ram_rd_data),
        .mtu              (mtu)
    );

    function automatic int total_errors();
        return errors + i_rx_interface.i_rx_interface_assertions.fail_count;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        checks++;
        assert (got === want) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Checks failed");
        $finish;
    endtask

    // DMA responder answers each accepted command with a status pulse two cycles later
    always @(posedge clk) begin
        dma_wr_desc_t want;
        if (rst) begin
            dma_desc_ready   <= 1'b0;
            dma_status_valid <= 1'b0;
            dma_status_error <= '0;
            status_delay     <= 0;
        end else begin
            dma_desc_ready   <= stall_en ? (($random(seed) & 3) == 0) : 1'b1;
            dma_status_valid <= 1'b0;
            if (status_delay == 1) begin
                dma_status_valid <= 1'b1;
                dma_status_error <= status_err;
            end
            if (status_delay != 0) begin
                status_delay <= status_delay - 1;
            end
            if (dma_desc_valid && dma_desc_ready) begin
                checks++;
                assert (want_dma.size() != 0) else begin
                    $display("DMA command issued at %0t with none expected", $time);
                    errors++;
                end
                if (want_dma.size() != 0) begin
                    want = want_dma.pop_front();
                    compare_value("dma_desc.dma_addr", dma_desc.dma_addr, want.dma_addr);
                    compare_value("dma_desc.ram_addr", dma_desc.ram_addr, want.ram_addr);
                    compare_value("dma_desc.len", dma_desc.len, want.len);
                end
                status_delay <= 2;
            end
        end
    end

    // Completion sink
    always @(posedge clk) begin
        rx_cpl_t want;
        if (rst) begin
            cpl_ready <= 1'b0;
        end else begin
            cpl_ready <= stall_en ? (($random(seed) & 3) == 0) : 1'b1;
            if (cpl_valid && cpl_ready) begin
                checks++;
                assert (want_cpl.size() != 0) else begin
                    $display("Completion arrived at %0t with none expected", $time);
                    errors++;
                end
                if (want_cpl.size() != 0) begin
                    want = want_cpl.pop_front();
                    compare_value("cpl.dma_addr", cpl.dma_addr, want.dma_addr);
                    compare_value("cpl.len", cpl.len, want.len);
                    compare_value("cpl.error", cpl.error, want.error);
                end
                cpl_count++;
            end
        end
    end

    // Good frames fit both mtu and the host buffer; every frame uses the next slot
    task automatic expect_frame(input logic [63:0] addr, input int len, input int buf_len);
        dma_wr_desc_t d;
        rx_cpl_t      c;
        bit           good;
        good = (len <= int'(mtu)) && (len <= buf_len);
        if (good) begin
            d.dma_addr = addr;
            d.ram_addr = (`RX_RAM_ADDR_WIDTH)'(exp_slot * `RX_SLOT_BYTES);
            d.len      = (`RX_LEN_WIDTH)'(len);
            want_dma.push_back(d);
        end
        c.dma_addr = addr;
        c.len      = (`RX_LEN_WIDTH)'(len);
        c.error    = !good || (status_err != '0);
        want_cpl.push_back(c);
        exp_slot = (exp_slot + 1) % `RX_SLOT_COUNT;
        frames_expected++;
    endtask

    task automatic push_desc(input logic [63:0] addr, input int buf_len);
        int cycles;
        desc.dma_addr <= addr;
        desc.buf_len  <= (`RX_LEN_WIDTH)'(buf_len);
        desc_valid    <= 1'b1;
        cycles = 0;
        @(posedge clk);
        while (!desc_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!desc_ready) begin
            stop_on_timeout("desc_ready");
        end
        desc_valid <= 1'b0;
    endtask

    task automatic send_frame(input int nbytes, input bit keep_copy);
        rx_beat_t beat;
        int       beats;
        int       rem;
        int       cycles;
        beats = (nbytes + `RX_KEEP_WIDTH - 1) / `RX_KEEP_WIDTH;
        for (int i = 0; i < beats; i++) begin
            rem = nbytes - i * `RX_KEEP_WIDTH;
            beat.data[31:0]  = $random(seed);
            beat.data[63:32] = $random(seed);
            beat.keep = (rem >= `RX_KEEP_WIDTH) ? '1 : (`RX_KEEP_WIDTH)'((1 << rem) - 1);
            beat.last = (i == beats - 1);
            if (keep_copy) begin
                sent_data.push_back(beat.data);
                sent_keep.push_back(beat.keep);
            end
            rx_beat  <= beat;
            rx_valid <= 1'b1;
            cycles = 0;
            @(posedge clk);
            while (!rx_ready && cycles < WAIT_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            if (!rx_ready) begin
                stop_on_timeout("rx_ready");
            end
        end
        rx_valid <= 1'b0;
    endtask

    task automatic wait_completions();
        int cycles;
        cycles = 0;
        while (cpl_count < frames_expected && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cpl_count < frames_expected) begin
            stop_on_timeout("completions");
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (rst && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            stop_on_timeout("end of reset");
        end
    endtask

    task automatic set_mtu(input int value);
        mtu <= (`RX_LEN_WIDTH)'(value);
        @(posedge clk);
    endtask

    // Registered read returns data the cycle after rd_en
    task automatic check_ram(input int base_word);
        logic [`RX_DATA_WIDTH-1:0] mask;
        for (int i = 0; i < sent_data.size(); i++) begin
            ram_rd_addr <= (`RX_RAM_WORD_ADDR_WIDTH)'(base_word + i);
            ram_rd_en   <= 1'b1;
            @(posedge clk);
            ram_rd_en <= 1'b0;
            @(posedge clk);
            for (int j = 0; j < `RX_KEEP_WIDTH; j++) begin
                mask[j*8 +: 8] = {8{sent_keep[i][j]}};
            end
            compare_value("ram_rd_data", ram_rd_data & mask, sent_data[i] & mask);
        end
    endtask

    task automatic finish_test(input string name);
        checks += 2;
        assert (want_dma.size() == 0) else begin
            $display("Expected DMA command never issued in test %s", name);
            errors++;
        end
        assert (want_cpl.size() == 0) else begin
            $display("Expected completion never arrived in test %s", name);
            errors++;
        end
        tests_run++;
        if (total_errors() == errors_at_start) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, total_errors() - errors_at_start);
        end
        errors_at_start = total_errors();
    endtask

    initial begin
        wait_reset();

        expect_frame(64'h0000_0001_1000_0000, 45, 512);
        push_desc(64'h0000_0001_1000_0000, 512);
        send_frame(45, 1'b1);
        wait_completions();
        check_ram(0);
        finish_test("1 single good frame");

        // Five frames walk the slots and wrap
        for (int k = 0; k < 5; k++) begin
            expect_frame(64'h0000_0002_2000_0000 + k * 4096, 64 + 9 * k, 1024);
            push_desc(64'h0000_0002_2000_0000 + k * 4096, 1024);
            send_frame(64 + 9 * k, 1'b0);
        end
        wait_completions();
        finish_test("2 slot rotation");

        set_mtu(256);
        expect_frame(64'h0000_0003_3000_0000, 300, 1024);
        push_desc(64'h0000_0003_3000_0000, 1024);
        send_frame(300, 1'b0);
        wait_completions();
        set_mtu(1500);
        expect_frame(64'h0000_0003_3000_1000, 200, 128);
        push_desc(64'h0000_0003_3000_1000, 128);
        send_frame(200, 1'b0);
        wait_completions();
        finish_test("3 length errors");

        status_err = 4'h3;
        expect_frame(64'h0000_0004_4000_0000, 80, 512);
        push_desc(64'h0000_0004_4000_0000, 512);
        send_frame(80, 1'b0);
        wait_completions();
        status_err = '0;
        finish_test("4 DMA status error");

        // Frames wait for late descriptors under random back-pressure
        stall_en = 1'b1;
        expect_frame(64'h0000_0005_5000_0000, 96, 512);
        expect_frame(64'h0000_0005_5000_0100, 150, 512);
        expect_frame(64'h0000_0005_5000_0200, 33, 512);
        fork
            begin
                send_frame(96, 1'b0);
                send_frame(150, 1'b0);
                send_frame(33, 1'b0);
            end
            begin
                repeat (20) @(posedge clk);
                push_desc(64'h0000_0005_5000_0000, 512);
                push_desc(64'h0000_0005_5000_0100, 512);
                push_desc(64'h0000_0005_5000_0200, 512);
            end
        join
        wait_completions();
        stall_en = 1'b0;
        finish_test("5 late descriptors with back-pressure");

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
